//--- design/sdmac_config.svh
// Bus widths, register offsets and DMA address step for the SCSI DMA controller
// Included by the package and by every block that decodes offsets
`ifndef SDMAC_CONFIG_SVH
`define SDMAC_CONFIG_SVH

// Register window, CPU data and word counter widths
`define SDMAC_ADDR_W 8
`define SDMAC_DATA_W 32
`define SDMAC_WTC_W  24

// Register offsets inside the 8-bit window
`define SDMAC_OFS_WTC     8'h04
`define SDMAC_OFS_CONTR   8'h08
`define SDMAC_OFS_ACR     8'h0C
`define SDMAC_OFS_ST_DMA  8'h10
`define SDMAC_OFS_FLUSH   8'h14
`define SDMAC_OFS_CLR_INT 8'h18
`define SDMAC_OFS_ISTR    8'h1C
`define SDMAC_OFS_SP_DMA  8'h3C

// Everything from here up belongs to the external SCSI chip
`define SDMAC_OFS_CHIP 8'h40

// Bytes per transferred word
`define SDMAC_ACR_STEP 32'd4

`endif

//--- design/sdmac_pkg.sv
// Shared types for the SCSI DMA controller
// Blocks refer to these by scoped name, compile this file before the RTL
`include "sdmac_config.svh"

package sdmac_pkg;

  // Offset inside the register window
  typedef logic [`SDMAC_ADDR_W-1:0] reg_addr_t;

  // One CPU data word
  typedef logic [`SDMAC_DATA_W-1:0] bus_data_t;

  // Memory address presented during DMA
  typedef logic [31:0] dma_addr_t;

  // Transferred word count
  typedef logic [`SDMAC_WTC_W-1:0] wtc_t;

  // CPU cycle sequencer states
  typedef enum logic [2:0] {
    IDLE,
    REG_ACK,
    CHIP_REQ,
    CHIP_ACK,
    RELEASE
  } bus_state_t;

  // Per-word SCSI handshake states
  typedef enum logic [1:0] {
    OFF,
    WAIT_DRQ,
    ACK_HIGH
  } dma_state_t;

endpackage

//--- design/addr_decoder.sv
// Decodes the CPU register window into read, write and action strobes
// Purely combinational, the strobes stay high for the whole address strobe
`timescale 1ns/10ps
`include "sdmac_config.svh"

module addr_decoder (
  input  sdmac_pkg::reg_addr_t addr,
  input  logic                 dmac_n,
  input  logic                 as_n,
  input  logic                 rw,
  input  logic                 dmadir,
  output logic                 reg_sel,
  output logic                 wtc_rd,
  output logic                 contr_rd,
  output logic                 contr_wr,
  output logic                 acr_wr,
  output logic                 istr_rd,
  output logic                 st_dma,
  output logic                 sp_dma,
  output logic                 clr_int,
  output logic                 flush,
  output logic                 chip_sel
);

  logic valid;
  logic hit_wtc;
  logic hit_contr;
  logic hit_acr;
  logic hit_st;
  logic hit_flush;
  logic hit_clr;
  logic hit_istr;
  logic hit_sp;

  // Chip select and address strobe both low
  assign valid = ~(dmac_n | as_n);

  // Exact offset matches
  assign hit_wtc   = valid && (addr == `SDMAC_OFS_WTC);
  assign hit_contr = valid && (addr == `SDMAC_OFS_CONTR);
  assign hit_acr   = valid && (addr == `SDMAC_OFS_ACR);
  assign hit_st    = valid && (addr == `SDMAC_OFS_ST_DMA);
  assign hit_flush = valid && (addr == `SDMAC_OFS_FLUSH);
  assign hit_clr   = valid && (addr == `SDMAC_OFS_CLR_INT);
  assign hit_istr  = valid && (addr == `SDMAC_OFS_ISTR);
  assign hit_sp    = valid && (addr == `SDMAC_OFS_SP_DMA);

  // Split between own registers and the SCSI chip
  assign chip_sel = valid && (addr >= `SDMAC_OFS_CHIP);
  // Any own offset gets an acknowledge, matched or not
  assign reg_sel  = valid && (addr < `SDMAC_OFS_CHIP);

  // Read and write strobes, rw high means read
  assign wtc_rd   = hit_wtc & rw;
  assign contr_rd = hit_contr & rw;
  assign contr_wr = hit_contr & ~rw;
  assign acr_wr   = hit_acr & ~rw;
  assign istr_rd  = hit_istr & rw;

  // Action strobes fire on any access to their offset
  assign st_dma  = hit_st;
  assign sp_dma  = hit_sp;
  assign clr_int = hit_clr;
  // Flush only means something when sending to the SCSI side
  assign flush   = hit_flush & dmadir;

endmodule

//--- design/cpu_bus_ctrl.sv
// CPU cycle sequencer: turns level strobes into one-cycle pulses,
// forwards chip window accesses and drives the data strobe acknowledge
`timescale 1ns/10ps
`include "sdmac_config.svh"

module cpu_bus_ctrl (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 as_n,
  input  logic                 reg_sel,
  input  logic                 wtc_rd,
  input  logic                 contr_rd,
  input  logic                 contr_wr,
  input  logic                 acr_wr,
  input  logic                 istr_rd,
  input  logic                 st_dma,
  input  logic                 sp_dma,
  input  logic                 clr_int,
  input  logic                 flush,
  input  logic                 chip_sel,
  input  logic                 chip_ack,
  output logic                 contr_we,
  output logic                 acr_we,
  output logic                 start,
  output logic                 stop,
  output logic                 clr_int_p,
  output logic                 flush_p,
  output sdmac_pkg::reg_addr_t rd_sel,
  output logic                 chip_req,
  output logic                 dsack_n
);

  sdmac_pkg::bus_state_t state;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state     <= sdmac_pkg::IDLE;
      contr_we  <= 1'b0;
      acr_we    <= 1'b0;
      start     <= 1'b0;
      stop      <= 1'b0;
      clr_int_p <= 1'b0;
      flush_p   <= 1'b0;
      rd_sel    <= '0;
      chip_req  <= 1'b0;
      dsack_n   <= 1'b1;
    end else begin
      // Pulses last a single clock
      contr_we  <= 1'b0;
      acr_we    <= 1'b0;
      start     <= 1'b0;
      stop      <= 1'b0;
      clr_int_p <= 1'b0;
      flush_p   <= 1'b0;
      case (state)
        sdmac_pkg::IDLE: begin
          if (!as_n && reg_sel) begin
            contr_we  <= contr_wr;
            acr_we    <= acr_wr;
            start     <= st_dma;
            stop      <= sp_dma;
            clr_int_p <= clr_int;
            flush_p   <= flush;
            // Latch the readable offset, anything else reads as zero
            if (wtc_rd) begin
              rd_sel <= `SDMAC_OFS_WTC;
            end else if (contr_rd) begin
              rd_sel <= `SDMAC_OFS_CONTR;
            end else if (istr_rd) begin
              rd_sel <= `SDMAC_OFS_ISTR;
            end else begin
              rd_sel <= '0;
            end
            state <= sdmac_pkg::REG_ACK;
          end else if (!as_n && chip_sel) begin
            rd_sel <= '0;
            state  <= sdmac_pkg::CHIP_REQ;
          end
        end
        // Register update lands on this edge, data is already on dout
        sdmac_pkg::REG_ACK: begin
          dsack_n <= 1'b0;
          state   <= sdmac_pkg::RELEASE;
        end
        sdmac_pkg::CHIP_REQ: begin
          chip_req <= 1'b1;
          state    <= sdmac_pkg::CHIP_ACK;
        end
        // Chip decides the latency
        sdmac_pkg::CHIP_ACK: begin
          if (chip_ack) begin
            dsack_n <= 1'b0;
            state   <= sdmac_pkg::RELEASE;
          end
        end
        sdmac_pkg::RELEASE: begin
          if (as_n) begin
            dsack_n  <= 1'b1;
            chip_req <= 1'b0;
          end
          // Chip handshake has to be back to zero before the next cycle
          if ((as_n || dsack_n) && !chip_req && !chip_ack) begin
            state <= sdmac_pkg::IDLE;
          end
        end
        default: state <= sdmac_pkg::IDLE;
      endcase
    end
  end

  // Acknowledge only answers a strobe the CPU still holds
  a_dsack_in_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(dsack_n) |-> !$past(as_n))
    else $error("dsack_n fell outside a CPU cycle");

  // Level decode fires each action once, before the cycle is acknowledged
  a_pulse_single: assert property (@(posedge clk) disable iff (!arst_n)
    (|{contr_we, acr_we, start, stop, clr_int_p, flush_p}) |-> dsack_n)
    else $error("action pulse inside an acknowledged CPU cycle");

endmodule

//--- design/sdmac_regs.sv
// CONTR and ISTR registers, interrupt pending logic and CPU read multiplexer
// Written through one-cycle pulses from the bus sequencer
`timescale 1ns/10ps
`include "sdmac_config.svh"

module sdmac_regs (
  input  logic                 clk,
  input  logic                 arst_n,
  input  sdmac_pkg::bus_data_t din,
  input  logic                 contr_we,
  input  logic                 clr_int_p,
  input  sdmac_pkg::reg_addr_t rd_sel,
  input  logic                 scsi_irq,
  input  sdmac_pkg::wtc_t      wtc,
  input  logic                 dma_active,
  input  logic                 flushed,
  output logic                 dmadir,
  output logic                 intena,
  output sdmac_pkg::bus_data_t dout,
  output logic                 int_n
);

  logic                 irq_q;
  logic                 int_pending;
  sdmac_pkg::bus_data_t contr_val;
  sdmac_pkg::bus_data_t istr_val;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dmadir      <= 1'b0;
      intena      <= 1'b0;
      irq_q       <= 1'b0;
      int_pending <= 1'b0;
    end else begin
      irq_q <= scsi_irq;
      // CONTR bit 1 direction, bit 2 interrupt enable
      if (contr_we) begin
        dmadir <= din[1];
        intena <= din[2];
      end
      // New chip interrupt beats a clear in the same clock
      if (scsi_irq && !irq_q) begin
        int_pending <= 1'b1;
      end else if (clr_int_p) begin
        int_pending <= 1'b0;
      end
    end
  end

  always_comb begin
    contr_val    = '0;
    contr_val[1] = dmadir;
    contr_val[2] = intena;
    // ISTR layout
    istr_val     = '0;
    istr_val[0]  = int_pending;
    istr_val[1]  = dma_active;
    istr_val[2]  = flushed;
    case (rd_sel)
      `SDMAC_OFS_WTC:   dout = {{(`SDMAC_DATA_W - `SDMAC_WTC_W){1'b0}}, wtc};
      `SDMAC_OFS_CONTR: dout = contr_val;
      `SDMAC_OFS_ISTR:  dout = istr_val;
      default:          dout = '0;
    endcase
  end

  // Masked by the enable, pending stays visible in ISTR
  assign int_n = ~(int_pending & intena);

endmodule

//--- design/dma_engine.sv
// DMA engine: answers SCSI data requests word by word and
// keeps the memory address and word counters for the transfer
`timescale 1ns/10ps
`include "sdmac_config.svh"

module dma_engine (
  input  logic                  clk,
  input  logic                  arst_n,
  input  sdmac_pkg::bus_data_t  din,
  input  logic                  acr_we,
  input  logic                  start,
  input  logic                  stop,
  input  logic                  flush_p,
  input  logic                  dmadir,
  input  logic                  scsi_drq,
  output logic                  scsi_dack,
  output sdmac_pkg::dma_addr_t  dma_addr,
  output logic                  dma_wr,
  output sdmac_pkg::wtc_t       wtc,
  output logic                  dma_active,
  output logic                  flushed
);

  sdmac_pkg::dma_state_t state;
  logic                  run;

  // Active state as it will be after this edge
  assign run = (dma_active | start) & ~stop & ~flush_p;

  // Write to memory when data comes from the SCSI side
  assign dma_wr = ~dmadir;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= sdmac_pkg::OFF;
      scsi_dack  <= 1'b0;
      dma_addr   <= '0;
      wtc        <= '0;
      dma_active <= 1'b0;
      flushed    <= 1'b0;
    end else begin
      if (start) begin
        wtc        <= '0;
        flushed    <= 1'b0;
        dma_active <= 1'b1;
      end
      if (stop) begin
        dma_active <= 1'b0;
      end
      if (flush_p) begin
        dma_active <= 1'b0;
        flushed    <= 1'b1;
      end
      // CPU load of the address counter
      if (acr_we) begin
        dma_addr <= din;
      end
      case (state)
        sdmac_pkg::OFF: begin
          if (run) begin
            state <= sdmac_pkg::WAIT_DRQ;
          end
        end
        sdmac_pkg::WAIT_DRQ: begin
          if (!run) begin
            state <= sdmac_pkg::OFF;
          end else if (scsi_drq) begin
            scsi_dack <= 1'b1;
            state     <= sdmac_pkg::ACK_HIGH;
          end
        end
        sdmac_pkg::ACK_HIGH: begin
          if (!run) begin
            // Aborted word, nothing counted
            scsi_dack <= 1'b0;
            state     <= sdmac_pkg::OFF;
          end else if (!scsi_drq) begin
            scsi_dack <= 1'b0;
            wtc       <= wtc + 1'b1;
            if (!acr_we) begin
              dma_addr <= dma_addr + `SDMAC_ACR_STEP;
            end
            state <= sdmac_pkg::WAIT_DRQ;
          end
        end
        default: state <= sdmac_pkg::OFF;
      endcase
    end
  end

  // Stop and flush drop the acknowledge in the same clock
  a_dack_inactive: assert property (@(posedge clk) disable iff (!arst_n)
    !dma_active |-> !scsi_dack)
    else $error("scsi_dack high with DMA inactive");

  // Address only moves at the end of a word or on a CPU load
  a_addr_step: assert property (@(posedge clk) disable iff (!arst_n)
    !$stable(dma_addr) |-> ($fell(scsi_dack) || $past(acr_we)))
    else $error("dma_addr changed outside a word handshake");

endmodule

//--- design/sdmac_top.sv
// SCSI DMA controller top level
// CPU register port, forward path to the SCSI chip and the DMA handshake
`timescale 1ns/10ps

module sdmac_top (
  input  logic                 clk,
  input  logic                 arst_n,
  // CPU side
  input  sdmac_pkg::reg_addr_t addr,
  input  sdmac_pkg::bus_data_t din,
  input  logic                 rw,
  input  logic                 dmac_n,
  input  logic                 as_n,
  output sdmac_pkg::bus_data_t dout,
  output logic                 dsack_n,
  // Chip window forward
  output logic                 chip_req,
  input  logic                 chip_ack,
  // SCSI data handshake
  input  logic                 scsi_drq,
  output logic                 scsi_dack,
  output sdmac_pkg::dma_addr_t dma_addr,
  output logic                 dma_wr,
  // Interrupts
  input  logic                 scsi_irq,
  output logic                 int_n
);

  // Decode strobes
  logic reg_sel;
  logic wtc_rd;
  logic contr_rd;
  logic contr_wr;
  logic acr_wr;
  logic istr_rd;
  logic st_dma;
  logic sp_dma;
  logic clr_int;
  logic flush;
  logic chip_sel;

  // Sequencer pulses and latched read offset
  logic                 contr_we;
  logic                 acr_we;
  logic                 start;
  logic                 stop;
  logic                 clr_int_p;
  logic                 flush_p;
  sdmac_pkg::reg_addr_t rd_sel;

  // Register and engine cross links
  logic            dmadir;
  logic            intena;
  sdmac_pkg::wtc_t wtc;
  logic            dma_active;
  logic            flushed;

  addr_decoder i_addr_decoder (.*);

  cpu_bus_ctrl i_cpu_bus_ctrl (.*);

  sdmac_regs i_sdmac_regs (.*);

  dma_engine i_dma_engine (.*);

endmodule

//--- tb/tb_sdmac_checker.sv
// Watches the DUT pins and compares them with values queued by the testbench
// Read data pops on a new dsack_n, DMA address and direction on a new scsi_dack
`timescale 1ns/10ps
`include "sdmac_config.svh"

module tb_sdmac_checker (
  input logic                 clk,
  input logic                 arst_n,
  input sdmac_pkg::reg_addr_t addr,
  input sdmac_pkg::bus_data_t dout,
  input logic                 dsack_n,
  input logic                 rw,
  input logic                 chip_req,
  input logic                 chip_ack,
  input logic                 scsi_dack,
  input sdmac_pkg::dma_addr_t dma_addr,
  input logic                 dma_wr,
  input logic                 int_n
);

  // Expected values in arrival order
  sdmac_pkg::bus_data_t read_q[$];
  sdmac_pkg::dma_addr_t addr_q[$];
  logic                 wr_q[$];
  logic                 int_q[$];

  logic dsack_q;
  logic dack_q;
  // Chip acknowledge seen during the current forward
  logic ack_seen;
  int   checks = 0;
  int   errors = 0;

  task automatic expect_read(input sdmac_pkg::bus_data_t value);
    read_q.push_back(value);
  endtask

  // Address and memory write flag of one word
  task automatic expect_addr(input sdmac_pkg::dma_addr_t value, input logic wr);
    addr_q.push_back(value);
    wr_q.push_back(wr);
  endtask

  // Compared at the next rising edge
  task automatic expect_int_n(input logic value);
    int_q.push_back(value);
  endtask

  // Expectations that never met their handshake
  function automatic int pending();
    return read_q.size() + addr_q.size() + int_q.size();
  endfunction

  always @(posedge clk or negedge arst_n) begin : compare
    sdmac_pkg::bus_data_t exp_data;
    sdmac_pkg::dma_addr_t exp_addr;
    logic                 exp_wr;
    logic                 exp_int;
    if (!arst_n) begin
      dsack_q  <= 1'b1;
      dack_q   <= 1'b0;
      ack_seen <= 1'b0;
    end else begin
      dsack_q <= dsack_n;
      dack_q  <= scsi_dack;
      if (!chip_req) begin
        ack_seen <= 1'b0;
      end else if (chip_ack) begin
        ack_seen <= 1'b1;
      end
      // New CPU acknowledge
      if (dsack_q && !dsack_n) begin
        if (addr >= `SDMAC_OFS_CHIP && !ack_seen) begin
          $display("dsack_n came before chip_ack on a chip window cycle at %0t", $time);
          errors = errors + 1;
        end
        if (rw) begin
          if (read_q.size() == 0) begin
            $display("Read acknowledged with no expected value at %0t", $time);
            errors = errors + 1;
          end else begin
            exp_data = read_q.pop_front();
            checks   = checks + 1;
            if (dout !== exp_data) begin
              $display("error: dout 0x%08h expected 0x%08h at %0t", dout, exp_data, $time);
              errors = errors + 1;
            end
          end
        end
      end
      // New word handshake, address stays put until dack falls
      if (!dack_q && scsi_dack) begin
        if (addr_q.size() == 0) begin
          $display("scsi_dack raised with no word expected at %0t", $time);
          errors = errors + 1;
        end else begin
          exp_addr = addr_q.pop_front();
          exp_wr   = wr_q.pop_front();
          checks   = checks + 1;
          if (dma_addr !== exp_addr) begin
            $display("error: dma_addr 0x%08h expected 0x%08h at %0t", dma_addr, exp_addr,
                     $time);
            errors = errors + 1;
          end
          if (dma_wr !== exp_wr) begin
            $display("error: dma_wr 0x%h expected 0x%h at %0t", dma_wr, exp_wr, $time);
            errors = errors + 1;
          end
        end
      end
      if (int_q.size() != 0) begin
        exp_int = int_q.pop_front();
        checks  = checks + 1;
        if (int_n !== exp_int) begin
          $display("error: int_n 0x%h expected 0x%h at %0t", int_n, exp_int, $time);
          errors = errors + 1;
        end
      end
    end
  end

endmodule

//--- tb/tb_sdmac.sv
// Testbench for the SCSI DMA controller
// Runs the commands of tb/sdmac_patterns.txt on the CPU bus, models the SCSI chip
// and leaves the comparing to the checker instance
`timescale 1ns/10ps
`include "sdmac_config.svh"

module tb_sdmac;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;
  // Upper bound for one command, chip wait or a short transfer
  localparam int MAX_CMD_CYCLES = 120;

  logic                 clk = 1'b0;
  logic                 arst_n;
  sdmac_pkg::reg_addr_t addr;
  sdmac_pkg::bus_data_t din;
  logic                 rw;
  logic                 dmac_n;
  logic                 as_n;
  sdmac_pkg::bus_data_t dout;
  logic                 dsack_n;
  logic                 chip_req;
  logic                 chip_ack;
  logic                 scsi_drq;
  logic                 scsi_dack;
  sdmac_pkg::dma_addr_t dma_addr;
  logic                 dma_wr;
  logic                 scsi_irq;
  logic                 int_n;

  // Parsed commands
  logic [31:0] cmd_op[$];
  logic [31:0] cmd_ofs[$];
  logic [31:0] cmd_data[$];
  logic [31:0] cmd_exp[$];
  logic        loaded = 1'b0;
  int          bench_errors = 0;
  // Expected dma_wr, memory is written while CONTR direction is clear
  logic        mem_write = 1'b1;
  // Chip latency source
  logic [15:0] lfsr = 16'd61003;

  always #(CLK_PERIOD / 2) clk = ~clk;

  sdmac_top i_dut (.*);

  tb_sdmac_checker i_checker (.*);

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // One step per bit taken
  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val  = (val << 1) | int'(lfsr[0]);
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Full four-phase CPU cycle, read data goes to the checker first
  task automatic cpu_cycle(input logic is_read, input sdmac_pkg::reg_addr_t ofs,
                           input sdmac_pkg::bus_data_t wdata,
                           input sdmac_pkg::bus_data_t exp_data);
    @(negedge clk);
    if (is_read) begin
      i_checker.expect_read(exp_data);
    end
    addr   = ofs;
    din    = wdata;
    rw     = is_read;
    dmac_n = 1'b0;
    as_n   = 1'b0;
    while (dsack_n) @(negedge clk);
    // rw and addr stay until the next cycle
    as_n   = 1'b1;
    dmac_n = 1'b1;
    while (!dsack_n) @(negedge clk);
  endtask

  // Word handshakes, address n is first plus n steps
  task automatic dma_words(input int count, input sdmac_pkg::dma_addr_t first);
    int w;
    for (w = 0; w < count; w++) begin
      @(negedge clk);
      i_checker.expect_addr(first + `SDMAC_ACR_STEP * w, mem_write);
      scsi_drq = 1'b1;
      while (!scsi_dack) @(negedge clk);
      scsi_drq = 1'b0;
      while (scsi_dack) @(negedge clk);
    end
  endtask

  // Request held with DMA off, any dack is flagged by the checker
  task automatic drq_without_ack();
    @(negedge clk);
    scsi_drq = 1'b1;
    repeat (8) @(negedge clk);
    scsi_drq = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  task automatic irq_pulse(input logic exp_int_n);
    @(negedge clk);
    scsi_irq = 1'b1;
    repeat (2) @(negedge clk);
    scsi_irq = 1'b0;
    i_checker.expect_int_n(exp_int_n);
    @(negedge clk);
  endtask

  task automatic int_level(input logic exp_int_n);
    @(negedge clk);
    i_checker.expect_int_n(exp_int_n);
    @(negedge clk);
  endtask

  task automatic run_command(input int idx);
    logic [31:0] op;
    logic [31:0] ofs;
    logic [31:0] data;
    logic [31:0] exp_val;
    op      = cmd_op[idx];
    ofs     = cmd_ofs[idx];
    data    = cmd_data[idx];
    exp_val = cmd_exp[idx];
    case (op)
      "poke": begin
        cpu_cycle(1'b0, ofs[7:0], data, '0);
        // CONTR bit 1 set sends the words to the SCSI side
        if (ofs[7:0] == `SDMAC_OFS_CONTR) begin
          mem_write = ~data[1];
        end
      end
      "peek": cpu_cycle(1'b1, ofs[7:0], '0, exp_val);
      "xfer": dma_words(int'(data), exp_val);
      "sirq": irq_pulse(exp_val[0]);
      "intn": int_level(exp_val[0]);
      "nack": drq_without_ack();
      default: begin
        $display("Unknown command in pattern entry %0d", idx);
        bench_errors++;
      end
    endcase
  endtask

  // SCSI chip, answers forwarded cycles after 0 to 7 clocks
  initial begin : scsi_chip
    int wait_cycles;
    chip_ack = 1'b0;
    forever begin
      @(negedge clk);
      if (chip_req) begin
        take_bits(3, wait_cycles);
        repeat (wait_cycles) @(negedge clk);
        chip_ack = 1'b1;
        while (chip_req) @(negedge clk);
        chip_ack = 1'b0;
      end
    end
  end

  initial begin : stimulus
    int           fd;
    int           n;
    int           idx;
    int           leftover;
    logic [639:0] line;
    logic [31:0]  op;
    logic [31:0]  ofs;
    logic [31:0]  data;
    logic [31:0]  exp_val;
    arst_n   = 1'b0;
    addr     = '0;
    din      = '0;
    rw       = 1'b1;
    dmac_n   = 1'b1;
    as_n     = 1'b1;
    scsi_drq = 1'b0;
    scsi_irq = 1'b0;
    fd = $fopen("tb/sdmac_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file tb/sdmac_patterns.txt");
      bench_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        n    = $fgets(line, fd);
        // Comment lines open with a double slash
        if (n != 0) begin
          n = $sscanf(line, "%s %h %h %h", op, ofs, data, exp_val);
          if (n == 4 && op[15:0] != "//") begin
            cmd_op.push_back(op);
            cmd_ofs.push_back(ofs);
            cmd_data.push_back(data);
            cmd_exp.push_back(exp_val);
          end
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    for (idx = 0; idx < cmd_op.size(); idx++) begin
      run_command(idx);
    end
    repeat (4) @(negedge clk);
    leftover = i_checker.pending();
    if (leftover != 0) begin
      $display("%0d expected responses were never seen on the DUT pins", leftover);
      bench_errors++;
    end
    $display("Commands: %0d, checks: %0d, check errors: %0d, bench errors: %0d",
             cmd_op.size(), i_checker.checks, i_checker.errors, bench_errors);
    if (i_checker.errors == 0 && bench_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  // Run limit scales with the number of commands
  initial begin : watchdog
    int limit_ns;
    wait (loaded);
    limit_ns = (cmd_op.size() + RESET_CYCLES) * MAX_CMD_CYCLES * CLK_PERIOD;
    #(limit_ns);
    $display("Timeout: the command sequence did not finish within %0d ns", limit_ns);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- sdmac.f
+incdir+design
design/sdmac_pkg.sv
design/addr_decoder.sv
design/cpu_bus_ctrl.sv
design/sdmac_regs.sv
design/dma_engine.sv
design/sdmac_top.sv
tb/tb_sdmac_checker.sv
tb/tb_sdmac.sv

//--- Makefile
# Verilator lint and simulation of the SCSI DMA controller
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        := tb_sdmac
FILELIST   := sdmac.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -q "TESTS PASSED" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb/sdmac_patterns.txt
// Columns: command, offset, data, expected value (last three in hex)
// poke writes, peek reads and compares, xfer moves data words from the expected address
// sirq pulses scsi_irq then compares int_n, intn compares int_n, nack allows no scsi_dack
// CONTR round trip, write-only offsets read as zero
poke 08 00000006 00000000
peek 08 00000000 00000006
poke 08 00000000 00000000
peek 08 00000000 00000000
peek 0c 00000000 00000000
peek 14 00000000 00000000
peek 3c 00000000 00000000
// Four words from 0x1000
poke 0c 00001000 00000000
peek 0c 00000000 00000000
poke 10 00000000 00000000
peek 1c 00000000 00000002
xfer 00 00000004 00001000
peek 04 00000000 00000004
// Stop ends the transfer
poke 3c 00000000 00000000
peek 1c 00000000 00000000
nack 00 00000000 00000000
peek 04 00000000 00000004
// New address, start clears the word count
poke 0c 00020000 00000000
poke 10 00000000 00000000
peek 04 00000000 00000000
xfer 00 00000002 00020000
peek 04 00000000 00000002
// Flush ignored while dmadir is clear
poke 14 00000000 00000000
peek 1c 00000000 00000002
// Flush with dmadir set
poke 08 00000002 00000000
poke 14 00000000 00000000
peek 1c 00000000 00000004
nack 00 00000000 00000000
// Restart clears flushed
poke 10 00000000 00000000
peek 1c 00000000 00000002
poke 3c 00000000 00000000
peek 1c 00000000 00000000
// Interrupt masked, then enabled, then cleared
sirq 00 00000000 00000001
peek 1c 00000000 00000001
poke 08 00000006 00000000
intn 00 00000000 00000000
poke 18 00000000 00000000
peek 1c 00000000 00000000
intn 00 00000000 00000001
sirq 00 00000000 00000000
poke 18 00000000 00000000
intn 00 00000000 00000001
// Chip window with random latency
poke 40 000000a5 00000000
peek 44 00000000 00000000
poke c0 12345678 00000000
peek 7c 00000000 00000000
peek fc 00000000 00000000
